// ==== logic/coef_bank.sv ====
//**********************************************************
// one coefficient ram, top address bit picks the product region
// registered read, no read-during-write bypass
//**********************************************************
`timescale 1ns/100ps

module coef_bank (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [pwmul_pkg::row_width:0] wr_addr,   // {region, row}
    input  logic [pwmul_pkg::coef_width-1:0] wr_data,
    input  logic [pwmul_pkg::row_width:0] rd_addr,   // {region, row}
    output logic [pwmul_pkg::coef_width-1:0] rd_data
);
    import pwmul_pkg::*;

    // lower half input region, upper half product region
    logic [coef_width-1:0] mem [2*bank_rows];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== logic/mod_mul.sv ====
//**********************************************************
// a*b mod q, fixed q, barrett with one correction step
// inputs must be below q, one new pair per cycle
//**********************************************************
`timescale 1ns/100ps

module mod_mul (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [pwmul_pkg::coef_width-1:0] a,
    input  logic [pwmul_pkg::coef_width-1:0] b,
    output logic [pwmul_pkg::coef_width-1:0] p
);
    import pwmul_pkg::*;

    logic [coef_width-1:0]            a_r;
    logic [coef_width-1:0]            b_r;
    logic [prod_width-1:0]            prod_r;     // stage 2
    logic [prod_width-1:0]            prod_d;     // product kept alongside quotient
    logic [quot_width-1:0]            quot_r;     // stage 3
    logic [prod_width+quot_width-1:0] est_full;   // prod * m, before the shift
    logic [prod_width-1:0]            rem;        // below 2q
    logic [prod_width-1:0]            rem_fix;

    // quotient estimate, never above the true quotient, at most one short
    always_comb begin
        est_full = prod_r * quot_width'(barrett_m);
    end

    // remainder and the single correction
    always_comb begin
        rem = prod_d - quot_r * prod_width'(modulus_q);
        if (rem >= prod_width'(modulus_q)) begin
            rem_fix = rem - prod_width'(modulus_q);
        end else begin
            rem_fix = rem;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_r    <= '0;
            b_r    <= '0;
            prod_r <= '0;
            prod_d <= '0;
            quot_r <= '0;
            p      <= '0;
        end else begin
            // stage 1 operands
            a_r    <= a;
            b_r    <= b;
            // stage 2 full product
            prod_r <= a_r * b_r;
            // stage 3 quotient = (x*m) >> k
            quot_r <= est_full[barrett_k +: quot_width];
            prod_d <= prod_r;
            // stage 4 subtract and correct
            p      <= rem_fix[coef_width-1:0];
        end
    end

endmodule

// ==== logic/pwmul_ctrl.sv ====
//**********************************************************
// phase fsm for load, multiply, drain and read-out
// load_bram and start are only honoured in idle
//**********************************************************
`timescale 1ns/100ps

module pwmul_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            load_bram,
    input  logic                            start,
    output logic                            load_en,
    output logic [pwmul_pkg::row_width-1:0] load_row,
    output logic [pwmul_pkg::row_width-1:0] rd_row,
    output logic                            rd_region,
    output logic                            mul_odd,
    output logic                            wr_en,
    output logic [pwmul_pkg::row_width-1:0] wr_row,
    output logic                            wr_odd,
    output logic                            out_valid,
    output logic                            done
);
    import pwmul_pkg::*;

    logic [2:0]           state;
    logic [row_width:0]   cnt;        // system counter, msb is the odd pass in multiply
    logic                 issue;
    logic                 issue_odd;

    // write-back delay line
    logic [wb_delay-1:0]  sr_valid;
    logic [wb_delay-1:0]  sr_odd;
    logic [row_width-1:0] sr_row [wb_delay];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (load_bram) begin
                        state <= st_load;
                    end else if (start) begin
                        state <= st_mul;
                    end
                end
                st_load: begin                                 // one row per cycle
                    if (cnt == (row_width+1)'(bank_rows-1)) begin
                        state <= st_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_mul: begin                                  // even rows then odd rows
                    if (cnt == (row_width+1)'(2*bank_rows-1)) begin
                        state <= st_drain;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_drain: begin
                    // last wr_en sits in the final drain cycle
                    if (cnt == (row_width+1)'(wb_delay-1)) begin
                        state <= st_out;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_out: begin
                    if (cnt == (row_width+1)'(bank_rows-1)) begin
                        state <= st_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // read issue during multiply
    assign issue     = (state == st_mul);
    assign issue_odd = cnt[row_width];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sr_valid <= '0;
            sr_odd   <= '0;
            for (int i = 0; i < wb_delay; i++) begin
                sr_row[i] <= '0;
            end
        end else begin
            sr_valid <= {sr_valid[wb_delay-2:0], issue};
            sr_odd   <= {sr_odd[wb_delay-2:0], issue_odd};
            sr_row[0] <= rd_row;
            for (int i = 1; i < wb_delay; i++) begin
                sr_row[i] <= sr_row[i-1];
            end
        end
    end

    // out_valid trails the product read by one cycle, done marks its first cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= (state == st_out);
            done      <= (state == st_out) && (cnt == '0);
        end
    end

    assign load_en   = (state == st_load);
    assign load_row  = cnt[row_width-1:0];
    assign rd_row    = cnt[row_width-1:0];
    assign rd_region = (state == st_out);
    assign mul_odd   = sr_odd[0];            // lines up with bank read data
    assign wr_en     = sr_valid[wb_delay-1];
    assign wr_odd    = sr_odd[wb_delay-1];
    assign wr_row    = sr_row[wb_delay-1];

endmodule

// ==== logic/pwmul_lane.sv ====
//**********************************************************
// one lane: even bank, odd bank and one modular multiplier
// load has priority over product write-back on the write port
//**********************************************************
`timescale 1ns/100ps

module pwmul_lane (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             load_en,
    input  logic [pwmul_pkg::row_width-1:0]  load_row,
    input  logic [pwmul_pkg::coef_width-1:0] load_even,
    input  logic [pwmul_pkg::coef_width-1:0] load_odd,
    input  logic [pwmul_pkg::coef_width-1:0] key,
    input  logic [pwmul_pkg::row_width-1:0]  rd_row,
    input  logic                             rd_region,  // 1 reads products
    input  logic                             mul_odd,    // aligned with bank read data
    input  logic                             wr_en,
    input  logic [pwmul_pkg::row_width-1:0]  wr_row,
    input  logic                             wr_odd,
    output logic [pwmul_pkg::coef_width-1:0] rd_even,
    output logic [pwmul_pkg::coef_width-1:0] rd_odd
);
    import pwmul_pkg::*;

    logic [row_width:0]    wr_addr;
    logic [row_width:0]    rd_addr;
    logic [coef_width-1:0] wdata_even;
    logic [coef_width-1:0] wdata_odd;
    logic                  we_even;
    logic                  we_odd;
    logic [coef_width-1:0] mul_src;
    logic [coef_width-1:0] prod;

    // write port steering
    always_comb begin
        if (load_en) begin
            wr_addr    = {1'b0, load_row};   // input region
            wdata_even = load_even;
            wdata_odd  = load_odd;
        end else begin
            wr_addr    = {1'b1, wr_row};     // product region
            wdata_even = prod;
            wdata_odd  = prod;
        end
        we_even = load_en | (wr_en & ~wr_odd);
        we_odd  = load_en | (wr_en & wr_odd);
    end

    assign rd_addr = {rd_region, rd_row};   // both banks read the same row

    // multiplier source, even pass then odd pass
    assign mul_src = mul_odd ? rd_odd : rd_even;

    coef_bank u_bank_even (
        .clk     (clk),
        .wr_en   (we_even),
        .wr_addr (wr_addr),
        .wr_data (wdata_even),
        .rd_addr (rd_addr),
        .rd_data (rd_even)
    );

    coef_bank u_bank_odd (
        .clk     (clk),
        .wr_en   (we_odd),
        .wr_addr (wr_addr),
        .wr_data (wdata_odd),
        .rd_addr (rd_addr),
        .rd_data (rd_odd)
    );

    mod_mul u_mul (
        .clk   (clk),
        .reset (reset),
        .a     (mul_src),
        .b     (key),
        .p     (prod)
    );

endmodule

// ==== logic/pwmul_pkg.sv ====
//**********************************************************
// ring, lane and modulus constants for the key multiply path
// barrett constants only valid for products below 2**barrett_k
//**********************************************************
package pwmul_pkg;

    // coefficient container and modulus
    localparam int coef_width = 14;
    localparam int modulus_q  = 12289;              // prime, 13.6 bits

    // barrett reduction, x < 2**barrett_k
    localparam int barrett_k  = 28;
    localparam int barrett_m  = (1 << barrett_k) / modulus_q;

    // widths inside the multiplier
    localparam int prod_width = 2 * coef_width;     // full a*b
    localparam int quot_width = barrett_k - coef_width + 1; // quotient and m fit here

    // ring layout
    localparam int ring_size  = 64;
    localparam int lane_count = 4;
    localparam int bank_count = 2 * lane_count;     // even + odd bank per lane
    localparam int bank_rows  = ring_size / bank_count;
    localparam int row_width  = 3;                  // log2 of bank_rows

    // pipeline depths
    localparam int mul_latency = 4;                 // operand to result in mod_mul
    localparam int wb_delay    = mul_latency + 1;   // plus one cycle of bank read

    // controller phase encodings
    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_load  = 3'd1;
    localparam logic [2:0] st_mul   = 3'd2;
    localparam logic [2:0] st_drain = 3'd3;
    localparam logic [2:0] st_out   = 3'd4;

endpackage

// ==== logic/pwmul_top.sv ====
//**********************************************************
// top of the key multiply engine, 64 coefficients on 4 lanes
// secret_key must stay stable from start until done
//**********************************************************
`timescale 1ns/100ps

module pwmul_top (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                load_bram,
    input  logic                                                start,
    input  logic [pwmul_pkg::bank_count*pwmul_pkg::coef_width-1:0] bram_in,
    input  logic [pwmul_pkg::lane_count*pwmul_pkg::coef_width-1:0] secret_key,
    output logic                                                done,
    output logic [pwmul_pkg::bank_count*pwmul_pkg::coef_width-1:0] bram_out
);
    import pwmul_pkg::*;

    logic                              load_en;
    logic [row_width-1:0]              load_row;
    logic [row_width-1:0]              rd_row;
    logic                              rd_region;
    logic                              mul_odd;
    logic                              wr_en;
    logic [row_width-1:0]              wr_row;
    logic                              wr_odd;
    logic                              out_valid;
    logic [bank_count*coef_width-1:0]  rd_words;   // word b from bank b

    pwmul_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .load_bram (load_bram),
        .start     (start),
        .load_en   (load_en),
        .load_row  (load_row),
        .rd_row    (rd_row),
        .rd_region (rd_region),
        .mul_odd   (mul_odd),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_odd    (wr_odd),
        .out_valid (out_valid),
        .done      (done)
    );

    // lane k owns banks 2k and 2k+1 and key word k
    for (genvar k = 0; k < lane_count; k++) begin : g_lane
        pwmul_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .load_en   (load_en),
            .load_row  (load_row),
            .load_even (bram_in[(2*k)*coef_width +: coef_width]),
            .load_odd  (bram_in[(2*k+1)*coef_width +: coef_width]),
            .key       (secret_key[k*coef_width +: coef_width]),
            .rd_row    (rd_row),
            .rd_region (rd_region),
            .mul_odd   (mul_odd),
            .wr_en     (wr_en),
            .wr_row    (wr_row),
            .wr_odd    (wr_odd),
            .rd_even   (rd_words[(2*k)*coef_width +: coef_width]),
            .rd_odd    (rd_words[(2*k+1)*coef_width +: coef_width])
        );
    end

    // zero outside the 8 read-out rows
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bram_out <= '0;
        end else if (out_valid) begin
            bram_out <= rd_words;
        end else begin
            bram_out <= '0;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module pwmul_tb -o pwmul_sim

# let assertion errors reach the summary instead of stopping at the first one
out=$(./obj_dir/pwmul_sim +verilator+error+limit+1000)
echo "$out"

if grep -q 'All tests passed!' <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== sim.f ====
logic/pwmul_pkg.sv
logic/coef_bank.sv
logic/mod_mul.sv
logic/pwmul_lane.sv
logic/pwmul_ctrl.sv
logic/pwmul_top.sv
testbench/tb_clock_gen.sv
testbench/pwmul_asserts.sv
testbench/pwmul_tb.sv

// ==== testbench/pwmul_asserts.sv ====
//**********************************************************
// done spacing and reset checks, bound into pwmul_top
//**********************************************************
`timescale 1ns/100ps

module pwmul_asserts (
    input logic                                                clk,
    input logic                                                reset,
    input logic                                                done,
    input logic [pwmul_pkg::bank_count*pwmul_pkg::coef_width-1:0] bram_out
);
    import pwmul_pkg::*;

    logic [bank_rows-1:0] done_hist;   // done over the last 8 cycles
    int                   assert_errors = 0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_hist <= '0;
        end else begin
            done_hist <= {done_hist[bank_rows-2:0], done};
        end
    end

    // one cycle pulse
    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            assert_errors++;
            $error("done stayed high for a second cycle");
        end

    // read-out window is 8 rows long
    a_done_gap: assert property (@(posedge clk) disable iff (reset)
        done |-> (done_hist == '0))
        else begin
            assert_errors++;
            $error("done came back within 8 cycles of the previous done");
        end

    a_out_reset: assert property (@(posedge clk) $fell(reset) |-> (bram_out == '0))
        else begin
            assert_errors++;
            $error("bram_out not zero at the first cycle after reset");
        end

endmodule

bind pwmul_top pwmul_asserts i_asserts (
    .clk      (clk),
    .reset    (reset),
    .done     (done),
    .bram_out (bram_out)
);

// ==== testbench/pwmul_tb.sv ====
//**********************************************************
// table driven testbench with a model of the loaded polynomial
// inputs change on the falling edge and outputs are sampled there
//**********************************************************
`timescale 1ns/100ps

module pwmul_tb;
    import pwmul_pkg::*;

    typedef struct packed {
        logic [1:0]                       kind;       // 0 random 1 zero 2 q-1 3 ramp
        logic                             rand_keys;
        logic [lane_count*coef_width-1:0] keys;       // {k3, k2, k1, k0}
        logic                             reload;
        logic                             disturb;    // noise on inputs during multiply
    } test_entry_t;

    logic                             clk;
    logic                             reset;
    logic                             load_bram;
    logic                             start;
    logic                             done;
    logic [bank_count*coef_width-1:0] bram_in;
    logic [lane_count*coef_width-1:0] secret_key;
    logic [bank_count*coef_width-1:0] bram_out;
    test_entry_t                      tests [8];
    int                               coef [bank_count][bank_rows];  // input region model
    int                               seed;
    int                               value_errors;
    int                               timeout_errors;
    int                               done_latency;   // start to done, same on every run

    tb_clock_gen u_clk_gen (.clk(clk));

    pwmul_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .load_bram  (load_bram),
        .start      (start),
        .bram_in    (bram_in),
        .secret_key (secret_key),
        .done       (done),
        .bram_out   (bram_out)
    );

    function automatic int rand_coef();
        return int'($unsigned($random(seed)) % modulus_q);   // always below q
    endfunction

    // coefficient times its lane key mod q
    function automatic int expected(int b, int r);
        longint prod;
        prod = longint'(coef[b][r]) * longint'(secret_key[(b/2)*coef_width +: coef_width]);
        return int'(prod % modulus_q);
    endfunction

    task automatic check_word(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_zero_out();
        if (bram_out !== '0) begin
            value_errors++;
            $display("ERROR at %0t: bram_out expected 0, got %h", $time, bram_out);
        end
    endtask

    task automatic fill_pattern(input logic [1:0] kind);
        for (int b = 0; b < bank_count; b++) begin
            for (int r = 0; r < bank_rows; r++) begin
                case (kind)
                    2'd0: coef[b][r] = rand_coef();
                    2'd1: coef[b][r] = 0;
                    2'd2: coef[b][r] = modulus_q - 1;
                    default: coef[b][r] = ((r * bank_count + b) * 193) % modulus_q;
                endcase
            end
        end
    endtask

    // pulse then rows 0..7 on the following edges
    task automatic load_poly();
        @(negedge clk);
        load_bram = 1'b1;
        for (int r = 0; r < bank_rows; r++) begin
            @(negedge clk);
            load_bram = 1'b0;
            for (int b = 0; b < bank_count; b++) begin
                bram_in[b*coef_width +: coef_width] = coef_width'(coef[b][r]);
            end
        end
        @(negedge clk);
        bram_in = '0;
    endtask

    task automatic run_multiply(input logic disturb);
        int cycles;
        cycles = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1 && cycles < 200) begin
            check_zero_out();              // nothing out before done
            if (disturb) begin             // pulses land in the multiply phase
                load_bram = (cycles == 2);
                start     = (cycles == 5);
                for (int b = 0; b < bank_count; b++) begin
                    bram_in[b*coef_width +: coef_width] = coef_width'(rand_coef());
                end
            end
            cycles++;
            @(negedge clk);
        end
        bram_in = '0;
        if (done !== 1'b1) begin
            timeout_errors++;
            $display("timeout at %0t: done did not arrive within 200 cycles", $time);
        end else begin
            if (done_latency < 0) begin
                done_latency = cycles;     // first run sets the reference
            end else begin
                check_word("done latency", done_latency, cycles);
            end
            check_zero_out();              // done cycle itself
            for (int r = 0; r < bank_rows; r++) begin
                @(negedge clk);
                check_word("done", 0, int'(done));
                for (int b = 0; b < bank_count; b++) begin
                    check_word($sformatf("bram_out word %0d row %0d", b, r), expected(b, r),
                        int'(bram_out[b*coef_width +: coef_width]));
                end
            end
            repeat (3) begin               // back to idle outputs
                @(negedge clk);
                check_word("done", 0, int'(done));
                check_zero_out();
            end
        end
    endtask

    initial begin
        seed           = 20332;
        value_errors   = 0;
        timeout_errors = 0;
        done_latency   = -1;
        reset          = 1'b1;
        load_bram      = 1'b0;
        start          = 1'b0;
        bram_in        = '0;
        secret_key     = '0;
        // kind, rand_keys, keys {k3,k2,k1,k0}, reload, disturb
        tests[0] = '{2'd0, 1'b1, '0, 1'b1, 1'b0};
        tests[1] = '{2'd1, 1'b0, {14'd12288, 14'd1, 14'd0, 14'd5}, 1'b1, 1'b0};
        tests[2] = '{2'd2, 1'b0, {14'd12288, 14'd1, 14'd0, 14'd12288}, 1'b1, 1'b0};
        tests[3] = '{2'd3, 1'b0, {14'd1, 14'd12288, 14'd4097, 14'd0}, 1'b1, 1'b0};
        tests[4] = '{2'd0, 1'b1, '0, 1'b1, 1'b0};
        tests[5] = '{2'd0, 1'b1, '0, 1'b0, 1'b0};   // same input region with new keys
        tests[6] = '{2'd0, 1'b1, '0, 1'b1, 1'b1};
        tests[7] = '{2'd0, 1'b0, {14'd0, 14'd1, 14'd12288, 14'd3}, 1'b0, 1'b1};
        repeat (10) @(negedge clk);
        check_word("done", 0, int'(done));
        check_zero_out();
        reset = 1'b0;
        @(negedge clk);
        check_word("done", 0, int'(done));
        check_zero_out();
        foreach (tests[i]) begin
            if (tests[i].reload) begin
                fill_pattern(tests[i].kind);
                load_poly();
            end
            if (tests[i].rand_keys) begin
                for (int k = 0; k < lane_count; k++) begin
                    secret_key[k*coef_width +: coef_width] = coef_width'(rand_coef());
                end
            end else begin
                secret_key = tests[i].keys;
            end
            run_multiply(tests[i].disturb);
        end
        $display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
            timeout_errors, i_dut.i_asserts.assert_errors);
        if (value_errors == 0 && timeout_errors == 0 && i_dut.i_asserts.assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
//**********************************************************
// free-running 20 ns clock, low at time zero
//**********************************************************
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // half period
    end

endmodule
